//--- clock_480p.sv
// --------------------
// brings the PLL lock level into clk_pix and derives the pixel-domain reset
// --------------------
`timescale 1ns/100ps

module clock_480p (
    input  wire logic clk_pix,
    input  wire logic reset,
    input  wire logic pll_locked,
    output      logic clk_pix_locked,
    output      logic reset_pix
);

    // first synchronizer stage that may go metastable
    logic locked_meta;

    // two-flop synchronizer on the raw lock level
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            locked_meta    <= 1'b0;
            clk_pix_locked <= 1'b0;
        end else begin
            locked_meta    <= pll_locked;
            clk_pix_locked <= locked_meta;
        end
    end

    // downstream reset held while external reset is up or the PLL is unlocked
    always_ff @(posedge clk_pix) begin
        reset_pix <= reset | ~clk_pix_locked;
    end

    // a loss of lock must reach the pixel-domain reset within three edges
    a_unlock_resets: assert property (
        @(posedge clk_pix) disable iff (reset)
        !pll_locked |-> ##3 reset_pix
    );

endmodule

//--- display_480p.sv
// --------------------
// 640x480 raster counters with registered sync, data enable and coordinates
// hold in reset_pix until the pixel clock is stable
// --------------------
`timescale 1ns/100ps
`include "video_defines.svh"

module display_480p import video_pkg::*; (
    input  wire logic   clk_pix,
    input  wire logic   reset_pix,
    output      coord_t sx,
    output      coord_t sy,
    output      logic   hsync,
    output      logic   vsync,
    output      logic   de
);

    // last pixel and last line of the full raster including blanking
    localparam coord_t H_LAST = coord_t'(`H_RES + `H_FP + `H_SYNC + `H_BP - 1);
    localparam coord_t V_LAST = coord_t'(`V_RES + `V_FP + `V_SYNC + `V_BP - 1);

    // sync pulse windows inclusive at both ends
    localparam coord_t HS_START = coord_t'(`H_RES + `H_FP);
    localparam coord_t HS_END   = coord_t'(`H_RES + `H_FP + `H_SYNC - 1);
    localparam coord_t VS_START = coord_t'(`V_RES + `V_FP);
    localparam coord_t VS_END   = coord_t'(`V_RES + `V_FP + `V_SYNC - 1);

    // internal position one cycle ahead of the outputs
    coord_t x;
    coord_t y;

    // raster counters
    always_ff @(posedge clk_pix) begin
        if (reset_pix) begin
            x <= '0;
            y <= '0;
        end else if (x == H_LAST) begin
            x <= '0;
            // wrap to the top after the last line
            y <= (y == V_LAST) ? coord_t'(0) : y + coord_t'(1);
        end else begin
            x <= x + coord_t'(1);
        end
    end

    // outputs all come from the same position so they line up
    // first cycle after release shows (0,0) with de already high
    always_ff @(posedge clk_pix) begin
        if (reset_pix) begin
            sx    <= '0;
            sy    <= '0;
            de    <= 1'b0;
            hsync <= ~`SYNC_POL;
            vsync <= ~`SYNC_POL;
        end else begin
            sx    <= x;
            sy    <= y;
            de    <= (x < coord_t'(`H_RES)) && (y < coord_t'(`V_RES));
            hsync <= (x >= HS_START && x <= HS_END) ? `SYNC_POL : ~`SYNC_POL;
            vsync <= (y >= VS_START && y <= VS_END) ? `SYNC_POL : ~`SYNC_POL;
        end
    end

    // horizontal position stays inside the 800-pixel raster
    a_sx_range: assert property (
        @(posedge clk_pix) sx <= H_LAST
    );

    // data enable only ever starts at the left edge of a visible line
    a_de_visible: assert property (
        @(posedge clk_pix) disable iff (reset_pix)
        $rose(de) |-> (sx == '0) && (sy < coord_t'(`V_RES))
    );

endmodule

//--- dvi_480p.sv
// --------------------
// pixel-domain DVI core, board wrapper supplies clk_pix and the raw PLL lock
// pixels for a coordinate go on pix_r/g/b one cycle after it shows on sx/sy
// --------------------
`timescale 1ns/100ps

module dvi_480p import video_pkg::*, tmds_pkg::*; (
    input  wire logic   clk_pix,
    input  wire logic   reset,
    input  wire logic   pll_locked,
    input  wire pixel_t pix_r,
    input  wire pixel_t pix_g,
    input  wire pixel_t pix_b,
    output      coord_t sx,
    output      coord_t sy,
    output      logic   de,
    output      logic   hsync,
    output      logic   vsync,
    output      logic   clk_pix_locked,
    output      tmds_t  tmds_0,
    output      tmds_t  tmds_1,
    output      tmds_t  tmds_2
);

    // reset for timing and encoders, high until lock is through the synchronizer
    logic reset_pix;

    clock_480p clock_480p_inst (
        .clk_pix        (clk_pix),
        .reset          (reset),
        .pll_locked     (pll_locked),
        .clk_pix_locked (clk_pix_locked),
        .reset_pix      (reset_pix)
    );

    display_480p display_480p_inst (
        .clk_pix   (clk_pix),
        .reset_pix (reset_pix),
        .sx        (sx),
        .sy        (sy),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de)
    );

    // blue lane carries the syncs as {c1,c0} = {vsync,hsync}
    tmds_encoder tmds_ch0_inst (
        .clk_pix   (clk_pix),
        .reset_pix (reset_pix),
        .data      (pix_b),
        .ctrl      ({vsync, hsync}),
        .de        (de),
        .tmds      (tmds_0)
    );

    // green and red lanes send control 00 in blanking
    tmds_encoder tmds_ch1_inst (
        .clk_pix   (clk_pix),
        .reset_pix (reset_pix),
        .data      (pix_g),
        .ctrl      (2'b00),
        .de        (de),
        .tmds      (tmds_1)
    );

    tmds_encoder tmds_ch2_inst (
        .clk_pix   (clk_pix),
        .reset_pix (reset_pix),
        .data      (pix_r),
        .ctrl      (2'b00),
        .de        (de),
        .tmds      (tmds_2)
    );

endmodule

//--- dvi_cases.txt
// red green blue, then expected symbols for tmds_2 (red) tmds_1 (green) tmds_0 (blue)
// one pixel per line, fed from sx 0 of line 0, disparity starts at 0
000 0FF 010 100 200 1F0
000 0FF 055 3FF 0FF 133
000 0FF 0AA 100 0FF 233
0FF 000 00F 0FF 100 105
0FF 000 00F 200 3FF 3FA
010 055 00F 1F0 133 105
055 0AA 001 133 233 1FF
0AA 010 000 233 1F0 100
080 001 0FF 37F 300 0FF
080 001 080 180 1FF 180
001 080 000 1FF 180 3FF
001 080 0FF 300 180 200
00F 0FF 055 3FA 0FF 133
000 00F 001 100 105 1FF
0FF 000 001 0FF 3FF 300
0FF 000 001 200 100 300
055 0AA 080 133 233 37F
010 055 0AA 1F0 133 233
080 001 000 37F 1FF 100
001 080 000 1FF 180 3FF
000 0FF 010 100 200 1F0
00F 0FF 001 105 0FF 300
00F 000 0FF 3FA 100 200
0FF 00F 055 200 3FA 133
0AA 010 00F 233 1F0 3FA
000 0FF 080 3FF 0FF 37F
001 080 0FF 300 180 200
080 001 000 37F 1FF 3FF

//--- run_sim.sh
#!/usr/bin/env bash
# builds the DVI core testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    -f verilog.f \
    --top-module tb_dvi_480p \
    -o sim_dvi 2>&1 | tee build.log

# a failing run exits non-zero, the log decides the verdict
./obj_dir/sim_dvi > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
if ! grep -q "TEST OK" sim.log; then
    echo "simulation ended without a verdict, see sim.log"
    exit 1
fi
echo "simulation passed"

//--- tb_dvi_480p.sv
// --------------------
// self-checking testbench for the DVI core that reads pixels and symbols
// from dvi_cases.txt
// --------------------
`timescale 1ns/100ps
`include "video_defines.svh"

module tb_dvi_480p import video_pkg::*, tmds_pkg::*; ();

    localparam int N_CASES     = 28;
    localparam int H_TOTAL     = `H_RES + `H_FP + `H_SYNC + `H_BP;
    localparam int V_TOTAL     = `V_RES + `V_FP + `V_SYNC + `V_BP;
    localparam int FRAME_WAIT  = 420000;
    localparam int WATCHDOG    = 2 * FRAME_WAIT + 1000;

    logic   clk_pix;
    logic   reset;
    logic   pll_locked;
    pixel_t pix_r = '0;
    pixel_t pix_g = '0;
    pixel_t pix_b = '0;
    coord_t sx;
    coord_t sy;
    logic   de;
    logic   hsync;
    logic   vsync;
    logic   clk_pix_locked;
    tmds_t  tmds_0;
    tmds_t  tmds_1;
    tmds_t  tmds_2;

    // r, g, b, then expected tmds_2, tmds_1, tmds_0 per pixel
    logic [9:0] cases_mem [0:6*N_CASES-1];
    integer     seed;
    logic       checking = 1'b0;
    int         case_idx = 0;
    int         data_checks = 0;
    // lock-and-no-reset seen one and two cycles back
    logic       ok_d1 = 1'b0;
    logic       ok_d2 = 1'b0;
    // reference raster position
    int         exp_x = H_TOTAL - 1;
    int         exp_y = V_TOTAL - 1;
    // three cycles of expected timing levels waiting for their symbols
    logic       h_de [3];
    logic       h_hs [3];
    logic       h_vs [3];
    int         h_case [3] = '{-1, -1, -1};

    dvi_480p dvi_480p_inst (
        .clk_pix        (clk_pix),
        .reset          (reset),
        .pll_locked     (pll_locked),
        .pix_r          (pix_r),
        .pix_g          (pix_g),
        .pix_b          (pix_b),
        .sx             (sx),
        .sy             (sy),
        .de             (de),
        .hsync          (hsync),
        .vsync          (vsync),
        .clk_pix_locked (clk_pix_locked),
        .tmds_0         (tmds_0),
        .tmds_1         (tmds_1),
        .tmds_2         (tmds_2)
    );

    initial begin
        clk_pix = 1'b0;
        forever #5 clk_pix = ~clk_pix;
    end

    task automatic check_tmds(input string name, input tmds_t got, input tmds_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "symbol mismatch");
        end
    endtask

    task automatic check_coord(input string name, input coord_t got, input coord_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "coordinate mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "level mismatch");
        end
    endtask

    // DVI control symbol for {c1,c0}
    function automatic tmds_t ctrl_symbol(input logic [1:0] c);
        case (c)
            2'b00:   return TMDS_CTRL_00;
            2'b01:   return TMDS_CTRL_01;
            2'b10:   return TMDS_CTRL_10;
            default: return TMDS_CTRL_11;
        endcase
    endfunction

    function automatic logic sync_level(input logic active);
        return active ? `SYNC_POL : ~`SYNC_POL;
    endfunction

    // waits for clk_pix_locked to reach a level, gives up after max_cycles
    task automatic wait_for_lock_level(input logic level, input int max_cycles);
        int n;
        n = 0;
        while (clk_pix_locked !== level) begin
            if (n == max_cycles) begin
                $display("clk_pix_locked did not reach %0d within %0d cycles",
                    level, max_cycles);
                $display("TEST FAILED");
                $fatal(1, "lock timing");
            end else begin
                @(posedge clk_pix);
                n++;
            end
        end
    endtask

    // samples the outputs of the previous cycle on every edge
    always @(posedge clk_pix) begin
        logic        ok_now;
        int          fed;
        logic [31:0] rnd;
        logic        exp_de;
        logic        exp_hs;
        logic        exp_vs;
        ok_now = clk_pix_locked && !reset;
        // reset levels unless the raster is running
        exp_de = 1'b0;
        exp_hs = ~`SYNC_POL;
        exp_vs = ~`SYNC_POL;
        if (checking && ok_d2) begin
            // advance the reference one pixel
            if (exp_x == H_TOTAL - 1) begin
                exp_x = 0;
                exp_y = (exp_y == V_TOTAL - 1) ? 0 : exp_y + 1;
            end else begin
                exp_x++;
            end
            exp_de = (exp_x < `H_RES) && (exp_y < `V_RES);
            exp_hs = sync_level((exp_x >= `H_RES + `H_FP) &&
                (exp_x < `H_RES + `H_FP + `H_SYNC));
            exp_vs = sync_level((exp_y >= `V_RES + `V_FP) &&
                (exp_y < `V_RES + `V_FP + `V_SYNC));
            check_coord("sx", sx, coord_t'(exp_x));
            check_coord("sy", sy, coord_t'(exp_y));
            check_bit("de", de, exp_de);
            check_bit("hsync", hsync, exp_hs);
            check_bit("vsync", vsync, exp_vs);
            // symbols lag the coordinate by three cycles
            if (!h_de[2]) begin
                check_tmds("tmds_0", tmds_0, ctrl_symbol({h_vs[2], h_hs[2]}));
                check_tmds("tmds_1", tmds_1, TMDS_CTRL_00);
                check_tmds("tmds_2", tmds_2, TMDS_CTRL_00);
            end else if (h_case[2] >= 0) begin
                check_tmds("tmds_2", tmds_2, cases_mem[6*h_case[2] + 3]);
                check_tmds("tmds_1", tmds_1, cases_mem[6*h_case[2] + 4]);
                check_tmds("tmds_0", tmds_0, cases_mem[6*h_case[2] + 5]);
                data_checks++;
            end
        end else if (checking) begin
            // pixel domain held in reset
            check_coord("sx", sx, '0);
            check_coord("sy", sy, '0);
            check_bit("de", de, exp_de);
            check_bit("hsync", hsync, exp_hs);
            check_bit("vsync", vsync, exp_vs);
            check_tmds("tmds_0", tmds_0, TMDS_CTRL_11);
            check_tmds("tmds_1", tmds_1, TMDS_CTRL_11);
            check_tmds("tmds_2", tmds_2, TMDS_CTRL_11);
            exp_x = H_TOTAL - 1;
            exp_y = V_TOTAL - 1;
        end
        // pixel for the coordinate just shown with the cases first on line 0
        fed = -1;
        rnd = $random(seed);
        if (checking && ok_d2 && exp_de && exp_y == 0 && case_idx < N_CASES &&
            exp_x == case_idx) begin
            fed = case_idx;
            pix_r <= cases_mem[6*case_idx][7:0];
            pix_g <= cases_mem[6*case_idx + 1][7:0];
            pix_b <= cases_mem[6*case_idx + 2][7:0];
            case_idx++;
        end else begin
            pix_r <= rnd[7:0];
            pix_g <= rnd[15:8];
            pix_b <= rnd[23:16];
        end
        h_de[2] = h_de[1];
        h_hs[2] = h_hs[1];
        h_vs[2] = h_vs[1];
        h_case[2] = h_case[1];
        h_de[1] = h_de[0];
        h_hs[1] = h_hs[0];
        h_vs[1] = h_vs[0];
        h_case[1] = h_case[0];
        h_de[0] = exp_de;
        h_hs[0] = exp_hs;
        h_vs[0] = exp_vs;
        h_case[0] = fed;
        ok_d2 = ok_d1;
        ok_d1 = ok_now;
    end

    initial begin
        seed = 32'h8e89;
        reset = 1'b1;
        pll_locked = 1'b0;
        $readmemh("dvi_cases.txt", cases_mem);
        for (int i = 0; i < 10; i++) begin
            @(posedge clk_pix);
            if (i == 3) begin
                checking <= 1'b1;
            end
            if (i >= 2) begin
                check_bit("clk_pix_locked", clk_pix_locked, 1'b0);
            end
        end
        reset <= 1'b0;
        pll_locked <= 1'b1;
        @(posedge clk_pix);
        wait_for_lock_level(1'b1, 4);
        // first frame covers the cases and both sync windows
        // then run halfway down the next one
        repeat (FRAME_WAIT + FRAME_WAIT / 2) @(posedge clk_pix);
        // lock lost mid-frame
        pll_locked <= 1'b0;
        @(posedge clk_pix);
        wait_for_lock_level(1'b0, 4);
        repeat (20) @(posedge clk_pix);
        pll_locked <= 1'b1;
        @(posedge clk_pix);
        wait_for_lock_level(1'b1, 4);
        repeat (2000) @(posedge clk_pix);
        if (data_checks != N_CASES) begin
            $display("only %0d of %0d case pixels were checked", data_checks, N_CASES);
            $display("TEST FAILED");
            $fatal(1, "case coverage");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

    // watchdog sized for two frames plus margin
    initial begin
        repeat (WATCHDOG) @(posedge clk_pix);
        $display("simulation timed out after %0d cycles", WATCHDOG);
        $display("TEST FAILED");
        $fatal(1, "watchdog");
    end

endmodule

//--- tmds_encoder.sv
// --------------------
// TMDS 8b/10b encoder for one DVI lane in two pipeline stages
// de and ctrl arrive one cycle before the matching data
// --------------------
`timescale 1ns/100ps

module tmds_encoder import tmds_pkg::*; (
    input  wire logic       clk_pix,
    input  wire logic       reset_pix,
    input  wire pixel_t     data,
    input  wire logic [1:0] ctrl,
    input  wire logic       de,
    output      tmds_t      tmds
);

    // number of set bits in a byte
    function automatic logic [3:0] count_ones(input logic [7:0] v);
        logic [3:0] n;
        n = '0;
        for (int i = 0; i < 8; i++) begin
            n = n + 4'(v[i]);
        end
        return n;
    endfunction

    // transition-minimized word with bit 8 set when XOR was used
    function automatic logic [8:0] minimize(input pixel_t d, input logic use_xnor);
        logic [8:0] q;
        q[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            q[i] = use_xnor ? ~(q[i-1] ^ d[i]) : (q[i-1] ^ d[i]);
        end
        q[8] = ~use_xnor;
        return q;
    endfunction

    // input delay that lines de and ctrl up with the pixel
    logic       de_d;
    logic [1:0] ctrl_d;

    // stage 1 combinational results
    logic [3:0] ones_d;
    logic       use_xnor;
    logic [8:0] q_m;
    logic [3:0] ones_q;
    disp_t      bal;

    // stage 1 registers
    logic       de_s1;
    logic [1:0] ctrl_s1;
    logic [8:0] q_m_r;
    disp_t      bal_r;

    // stage 2 state and next values
    disp_t      disp;
    disp_t      disp_next;
    tmds_t      sym_next;

    // XNOR when ones exceed 4, or exactly 4 with bit 0 clear
    always_comb begin
        ones_d   = count_ones(data);
        use_xnor = (ones_d > 4'd4) || (ones_d == 4'd4 && !data[0]);
        q_m      = minimize(data, use_xnor);
        ones_q   = count_ones(q_m[7:0]);
        // ones minus zeros of the low byte from -8 to 8
        bal      = disp_t'({ones_q, 1'b0}) - 5'sd8;
    end

    always_ff @(posedge clk_pix) begin
        if (reset_pix) begin
            de_d  <= 1'b0;
            de_s1 <= 1'b0;
        end else begin
            de_d  <= de;
            de_s1 <= de_d;
        end
    end

    // payload pipeline for the control bits and the minimized word
    always_ff @(posedge clk_pix) begin
        ctrl_d  <= ctrl;
        ctrl_s1 <= ctrl_d;
        q_m_r   <= q_m;
        bal_r   <= bal;
    end

    // DC balancing against the running disparity
    always_comb begin
        if (!de_s1) begin
            disp_next = '0;
            case (ctrl_s1)
                2'b00:   sym_next = TMDS_CTRL_00;
                2'b01:   sym_next = TMDS_CTRL_01;
                2'b10:   sym_next = TMDS_CTRL_10;
                default: sym_next = TMDS_CTRL_11;
            endcase
        end else if (disp == 0 || bal_r == 0) begin
            // bit 9 only flags the inversion when there is no bias either way
            sym_next  = {~q_m_r[8], q_m_r[8], q_m_r[8] ? q_m_r[7:0] : ~q_m_r[7:0]};
            disp_next = q_m_r[8] ? disp + bal_r : disp - bal_r;
        end else if (disp[4] == bal_r[4]) begin
            // word would push further the same way so invert it
            sym_next  = {1'b1, q_m_r[8], ~q_m_r[7:0]};
            disp_next = disp + (q_m_r[8] ? 5'sd2 : 5'sd0) - bal_r;
        end else begin
            sym_next  = {1'b0, q_m_r[8], q_m_r[7:0]};
            disp_next = disp - (q_m_r[8] ? 5'sd0 : 5'sd2) + bal_r;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (reset_pix) begin
            disp <= '0;
            tmds <= TMDS_CTRL_11;
        end else begin
            disp <= disp_next;
            tmds <= sym_next;
        end
    end

    // balancing keeps the lane within a bounded DC offset
    a_disp_bounded: assert property (
        @(posedge clk_pix) disable iff (reset_pix)
        (disp >= -5'sd10) && (disp <= 5'sd10)
    );

endmodule

//--- tmds_pkg.sv
// --------------------
// link-side types and the DVI control symbols shared by encoder and testbench
// --------------------
package tmds_pkg;

    // one colour channel of a pixel
    typedef logic [7:0] pixel_t;

    // one 10-bit symbol on a TMDS lane
    typedef logic [9:0] tmds_t;

    // running disparity, signed count of ones minus zeros
    typedef logic signed [4:0] disp_t;

    // control symbols, suffix is {c1,c0}
    localparam tmds_t TMDS_CTRL_00 = 10'b1101010100;
    localparam tmds_t TMDS_CTRL_01 = 10'b0010101011;
    localparam tmds_t TMDS_CTRL_10 = 10'b0101010100;
    localparam tmds_t TMDS_CTRL_11 = 10'b1010101011;

endpackage

//--- verilog.f
+incdir+.
video_pkg.sv
tmds_pkg.sv
clock_480p.sv
display_480p.sv
tmds_encoder.sv
dvi_480p.sv
tb_dvi_480p.sv

//--- video_defines.svh
// --------------------
// 640x480 at 60 Hz display timing, include wherever raster limits are needed
// --------------------
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// horizontal timing in pixels
`define H_RES  640
`define H_FP   16
`define H_SYNC 96
`define H_BP   48

// vertical timing in lines
`define V_RES  480
`define V_FP   10
`define V_SYNC 2
`define V_BP   33

// 0 means sync pulses are active low
`define SYNC_POL 1'b0

`endif

//--- video_pkg.sv
// --------------------
// display-side types, import into anything that handles screen positions
// --------------------
package video_pkg;

    // screen coordinate, wide enough for the full 800x525 raster
    // blanking positions included, so 10 bits not 9
    typedef logic [9:0] coord_t;

endpackage
